// ==== files.f ====
+incdir+.
fpTypes.sv
fpSignUnit.sv
fpComparator.sv
fpClassifier.sv
fpExecute.sv
fpHandshake.sv
fpuTop.sv
tbFpuTop.sv

// ==== fpClassifier.sv ====
// FP classifier
// ten-way one-hot FCLASS decode of a single-precision value
`timescale 1ns/10ps
`default_nettype none

module fpClassifier (
    input  wire fpTypes::word_t value,
    output fpTypes::fpClass_t   fpClass
);

    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] fraction;
    logic        expZero;
    logic        expOnes;
    logic        fracZero;
    logic        finiteNormal;
    logic        isNan;

    assign sign     = value[31];
    assign exponent = value[30:23];
    assign fraction = value[22:0];

    assign expZero      = (exponent == 8'h00);
    assign expOnes      = (exponent == 8'hff);
    assign fracZero     = (fraction == 23'h0);
    assign finiteNormal = ~expZero & ~expOnes;
    assign isNan        = expOnes & ~fracZero;

    assign fpClass[0] = sign & expOnes & fracZero;      // -inf
    assign fpClass[1] = sign & finiteNormal;            // -normal
    assign fpClass[2] = sign & expZero & ~fracZero;     // -subnormal
    assign fpClass[3] = sign & expZero & fracZero;      // -0
    assign fpClass[4] = ~sign & expZero & fracZero;     // +0
    assign fpClass[5] = ~sign & expZero & ~fracZero;    // +subnormal
    assign fpClass[6] = ~sign & finiteNormal;           // +normal
    assign fpClass[7] = ~sign & expOnes & fracZero;     // +inf

    // NaN classes ignore the sign bit
    assign fpClass[8] = isNan & ~fraction[22];          // signaling
    assign fpClass[9] = isNan & fraction[22];           // quiet

endmodule

`default_nettype wire

// ==== fpComparator.sv ====
// FP comparator
// FEQ, FLT, FLE, FMIN and FMAX with NaN handling and the invalid flag
`timescale 1ns/10ps
`default_nettype none

`include "fpu_settings.svh"

module fpComparator (
    input  wire fpTypes::fpCmpCmd_t cmpCmd,
    input  wire fpTypes::word_t     fpSrc1,
    input  wire fpTypes::word_t     fpSrc2,
    output fpTypes::word_t          intResult,
    output fpTypes::word_t          fpResult,
    output fpTypes::fflags_t        flags
);

    logic        sign1;
    logic        sign2;
    logic [30:0] mag1;
    logic [30:0] mag2;
    logic        nan1;
    logic        nan2;
    logic        anyNan;
    logic        anySnan;
    logic        bothZero;
    logic        equal;
    logic        lessTotal;  // -0 ordered below +0
    logic        less;       // IEEE order, zeros equal

    assign sign1 = fpSrc1[31];
    assign sign2 = fpSrc2[31];
    assign mag1  = fpSrc1[30:0];
    assign mag2  = fpSrc2[30:0];

    assign nan1 = (fpSrc1[30:23] == 8'hff) && (fpSrc1[22:0] != 23'h0);
    assign nan2 = (fpSrc2[30:23] == 8'hff) && (fpSrc2[22:0] != 23'h0);

    assign anyNan  = nan1 | nan2;
    assign anySnan = (nan1 & ~fpSrc1[22]) | (nan2 & ~fpSrc2[22]);  // quiet bit clear

    assign bothZero = (mag1 == 31'h0) && (mag2 == 31'h0);
    assign equal    = (fpSrc1 == fpSrc2) || bothZero;

    // sign-magnitude order, larger magnitude is smaller when negative
    always_comb begin
        if (sign1 != sign2) begin
            lessTotal = sign1;
        end else if (sign1) begin
            lessTotal = mag1 > mag2;
        end else begin
            lessTotal = mag1 < mag2;
        end
    end

    assign less = lessTotal & ~bothZero;

    always_comb begin
        intResult = '0;
        fpResult  = '0;
        flags     = '0;
        case (cmpCmd)
            fpTypes::Eq: begin
                intResult[0]            = ~anyNan & equal;
                flags[`FPU_FLAG_NV]     = anySnan;  // quiet compare
            end
            fpTypes::Lt: begin
                intResult[0]            = ~anyNan & less;
                flags[`FPU_FLAG_NV]     = anyNan;   // signaling compare
            end
            fpTypes::Le: begin
                intResult[0]            = ~anyNan & (less | equal);
                flags[`FPU_FLAG_NV]     = anyNan;
            end
            fpTypes::Min, fpTypes::Max: begin
                if (nan1 && nan2) begin
                    fpResult = `FPU_CANON_NAN;
                end else if (nan1) begin
                    fpResult = fpSrc2;
                end else if (nan2) begin
                    fpResult = fpSrc1;
                end else if (lessTotal ^ (cmpCmd == fpTypes::Max)) begin
                    fpResult = fpSrc1;
                end else begin
                    fpResult = fpSrc2;
                end
                flags[`FPU_FLAG_NV] = anySnan;
            end
            default: begin
                flags = '0;  // no operation selected
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== fpExecute.sv ====
// FP execute block
// decodes the op, runs sign, compare and classify units, muxes results and flags
`timescale 1ns/10ps
`default_nettype none

module fpExecute (
    input  wire fpTypes::fpOp_t op,
    input  wire fpTypes::word_t intSrc,
    input  wire fpTypes::word_t fpSrc1,
    input  wire fpTypes::word_t fpSrc2,
    output fpTypes::word_t      intResult,
    output fpTypes::word_t      fpResult,
    output logic                writeFlags,
    output fpTypes::fflags_t    flagsValue
);

    fpTypes::fpSignCmd_t signCmd;
    fpTypes::fpCmpCmd_t  cmpCmd;
    fpTypes::word_t      signFpResult;
    fpTypes::word_t      cmpIntResult;
    fpTypes::word_t      cmpFpResult;
    fpTypes::fflags_t    cmpFlags;
    fpTypes::fpClass_t   classBits;

    // sub-commands, don't care when the unit is not selected
    always_comb begin
        case (op)
            fpTypes::FpOp_Sgnjn: signCmd = fpTypes::Sgnjn;
            fpTypes::FpOp_Sgnjx: signCmd = fpTypes::Sgnjx;
            default:             signCmd = fpTypes::Sgnj;
        endcase
    end

    always_comb begin
        case (op)
            fpTypes::FpOp_Lt:  cmpCmd = fpTypes::Lt;
            fpTypes::FpOp_Le:  cmpCmd = fpTypes::Le;
            fpTypes::FpOp_Min: cmpCmd = fpTypes::Min;
            fpTypes::FpOp_Max: cmpCmd = fpTypes::Max;
            default:           cmpCmd = fpTypes::Eq;
        endcase
    end

    fpSignUnit signUnit_i (
        .signCmd  (signCmd),
        .fpSrc1   (fpSrc1),
        .fpSrc2   (fpSrc2),
        .fpResult (signFpResult)
    );

    fpComparator comparator_i (
        .cmpCmd    (cmpCmd),
        .fpSrc1    (fpSrc1),
        .fpSrc2    (fpSrc2),
        .intResult (cmpIntResult),
        .fpResult  (cmpFpResult),
        .flags     (cmpFlags)
    );

    fpClassifier classifier_i (
        .value   (fpSrc1),
        .fpClass (classBits)
    );

    always_comb begin
        intResult  = '0;
        fpResult   = '0;
        writeFlags = 1'b0;
        flagsValue = '0;
        case (op)
            fpTypes::FpOp_MvXW: intResult = fpSrc1;  // raw bits to integer side
            fpTypes::FpOp_MvWX: fpResult  = intSrc;  // raw bits to FP side
            fpTypes::FpOp_Class: intResult = fpTypes::word_t'(classBits);
            fpTypes::FpOp_Sgnj, fpTypes::FpOp_Sgnjn, fpTypes::FpOp_Sgnjx: begin
                fpResult = signFpResult;
            end
            fpTypes::FpOp_Eq, fpTypes::FpOp_Lt, fpTypes::FpOp_Le,
            fpTypes::FpOp_Min, fpTypes::FpOp_Max: begin
                intResult  = cmpIntResult;
                fpResult   = cmpFpResult;
                writeFlags = 1'b1;
                flagsValue = cmpFlags;
            end
            default: writeFlags = 1'b0;  // illegal codes give all zeros
        endcase
    end

endmodule

`default_nettype wire

// ==== fpHandshake.sv ====
// FPU handshake controller
// four-phase req/ack, captures operands and registers execute results
`timescale 1ns/10ps
`default_nettype none

module fpHandshake (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire                   req,
    input  wire fpTypes::fpOp_t   op,
    input  wire fpTypes::word_t   intSrc,
    input  wire fpTypes::word_t   fpSrc1,
    input  wire fpTypes::word_t   fpSrc2,
    output logic                  ack,
    output fpTypes::fpOp_t        opReg,
    output fpTypes::word_t        intSrcReg,
    output fpTypes::word_t        fpSrc1Reg,
    output fpTypes::word_t        fpSrc2Reg,
    input  wire fpTypes::word_t   exIntResult,
    input  wire fpTypes::word_t   exFpResult,
    input  wire                   exWriteFlags,
    input  wire fpTypes::fflags_t exFlags,
    output fpTypes::word_t        intResult,
    output fpTypes::word_t        fpResult,
    output logic                  writeFlags,
    output fpTypes::fflags_t      flagsValue
);

    fpTypes::hsState_t state;
    logic              capture;

    assign capture = (state == fpTypes::HsIdle) && req;

    // operand registers, loaded when an idle unit sees req
    always_ff @(posedge clk) begin
        if (capture) begin
            opReg     <= op;
            intSrcReg <= intSrc;
            fpSrc1Reg <= fpSrc1;
            fpSrc2Reg <= fpSrc2;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= fpTypes::HsIdle;
            ack        <= 1'b0;
            intResult  <= '0;
            fpResult   <= '0;
            writeFlags <= 1'b0;
            flagsValue <= '0;
        end else begin
            case (state)
                fpTypes::HsIdle: begin
                    if (capture) begin
                        state <= fpTypes::HsExec;
                    end
                end
                fpTypes::HsExec: begin
                    state      <= fpTypes::HsAck;
                    ack        <= 1'b1;
                    intResult  <= exIntResult;   // only load point, held through ack
                    fpResult   <= exFpResult;
                    writeFlags <= exWriteFlags;
                    flagsValue <= exFlags;
                end
                fpTypes::HsAck: begin
                    if (!req) begin
                        state <= fpTypes::HsIdle;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= fpTypes::HsIdle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== fpSignUnit.sv ====
// FP sign unit
// FSGNJ, FSGNJN and FSGNJX on the magnitude of source 1
`timescale 1ns/10ps
`default_nettype none

module fpSignUnit (
    input  wire fpTypes::fpSignCmd_t signCmd,
    input  wire fpTypes::word_t      fpSrc1,
    input  wire fpTypes::word_t      fpSrc2,
    output fpTypes::word_t           fpResult
);

    logic sign1;
    logic sign2;
    logic newSign;

    assign sign1 = fpSrc1[31];
    assign sign2 = fpSrc2[31];

    always_comb begin
        case (signCmd)
            fpTypes::Sgnj: begin
                newSign = sign2;          // copy sign of src2
            end
            fpTypes::Sgnjn: begin
                newSign = ~sign2;         // inverted sign of src2
            end
            fpTypes::Sgnjx: begin
                newSign = sign1 ^ sign2;  // product of both signs
            end
            default: begin
                newSign = sign1;          // unused code, keep src1 as is
            end
        endcase
    end

    // exponent and fraction untouched, so NaN payloads pass through
    assign fpResult = {newSign, fpSrc1[30:0]};

endmodule

`default_nettype wire

// ==== fpTypes.sv ====
// fpTypes package
// word, flag and class vectors plus the op and FSM encodings of the FPU
`default_nettype none

`include "fpu_settings.svh"

package fpTypes;

    typedef logic [`FPU_XLEN-1:0]       word_t;     // integer or raw FP word
    typedef logic [4:0]                 fflags_t;   // NV DZ OF UF NX
    typedef logic [`FPU_CLASS_BITS-1:0] fpClass_t;  // one-hot, neg inf at bit 0

    // values 11 to 15 are illegal
    typedef enum logic [3:0] {
        FpOp_MvXW  = 4'd0,
        FpOp_MvWX  = 4'd1,
        FpOp_Class = 4'd2,
        FpOp_Sgnj  = 4'd3,
        FpOp_Sgnjn = 4'd4,
        FpOp_Sgnjx = 4'd5,
        FpOp_Eq    = 4'd6,
        FpOp_Lt    = 4'd7,
        FpOp_Le    = 4'd8,
        FpOp_Min   = 4'd9,
        FpOp_Max   = 4'd10
    } fpOp_t;

    typedef enum logic [1:0] {
        Sgnj  = 2'd0,
        Sgnjn = 2'd1,
        Sgnjx = 2'd2
    } fpSignCmd_t;

    typedef enum logic [2:0] {
        Eq  = 3'd0,
        Lt  = 3'd1,
        Le  = 3'd2,
        Min = 3'd3,
        Max = 3'd4
    } fpCmpCmd_t;

    typedef enum logic [1:0] {
        HsIdle = 2'd0,
        HsExec = 2'd1,
        HsAck  = 2'd2
    } hsState_t;

endpackage

`default_nettype wire

// ==== fpuTop.sv ====
// FPU integer-side unit top level
// connects the req/ack controller to the combinational execute block
`timescale 1ns/10ps
`default_nettype none

module fpuTop (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire                 req,
    input  wire fpTypes::fpOp_t op,
    input  wire fpTypes::word_t intSrc,
    input  wire fpTypes::word_t fpSrc1,
    input  wire fpTypes::word_t fpSrc2,
    output logic                ack,
    output fpTypes::word_t      intResult,
    output fpTypes::word_t      fpResult,
    output logic                writeFlags,
    output fpTypes::fflags_t    flagsValue
);

    fpTypes::fpOp_t   opReg;
    fpTypes::word_t   intSrcReg;
    fpTypes::word_t   fpSrc1Reg;
    fpTypes::word_t   fpSrc2Reg;
    fpTypes::word_t   exIntResult;
    fpTypes::word_t   exFpResult;
    logic             exWriteFlags;
    fpTypes::fflags_t exFlags;

    fpHandshake handshake_i (
        .clk          (clk),
        .arstN        (arstN),
        .req          (req),
        .op           (op),
        .intSrc       (intSrc),
        .fpSrc1       (fpSrc1),
        .fpSrc2       (fpSrc2),
        .ack          (ack),
        .opReg        (opReg),
        .intSrcReg    (intSrcReg),
        .fpSrc1Reg    (fpSrc1Reg),
        .fpSrc2Reg    (fpSrc2Reg),
        .exIntResult  (exIntResult),
        .exFpResult   (exFpResult),
        .exWriteFlags (exWriteFlags),
        .exFlags      (exFlags),
        .intResult    (intResult),
        .fpResult     (fpResult),
        .writeFlags   (writeFlags),
        .flagsValue   (flagsValue)
    );

    fpExecute execute_i (
        .op         (opReg),
        .intSrc     (intSrcReg),
        .fpSrc1     (fpSrc1Reg),
        .fpSrc2     (fpSrc2Reg),
        .intResult  (exIntResult),
        .fpResult   (exFpResult),
        .writeFlags (exWriteFlags),
        .flagsValue (exFlags)
    );

endmodule

`default_nettype wire

// ==== fpu_settings.svh ====
// single-precision FPU settings
// data widths, canonical NaN and flag bit positions
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

`define FPU_XLEN        32            // integer and raw FP word width
`define FPU_CLASS_BITS  10            // one-hot FCLASS result width
`define FPU_CANON_NAN   32'h7fc00000  // canonical quiet NaN
`define FPU_FLAG_NV     4             // invalid operation, flags are NV DZ OF UF NX

`endif

// ==== tbFpuTop.sv ====
// FPU integer-side unit testbench
// random and special operands through the req/ack port, checked against a reference model
`timescale 1ns/10ps
`default_nettype none

`include "fpu_settings.svh"

module tbFpuTop;

    typedef struct packed {
        fpTypes::word_t   intRes;
        fpTypes::word_t   fpRes;
        logic             wrFlags;
        fpTypes::fflags_t flags;
    } result_t;

    logic              clk;
    logic              arstN;
    logic              req;
    fpTypes::fpOp_t    op;
    fpTypes::word_t    intSrc;
    fpTypes::word_t    fpSrc1;
    fpTypes::word_t    fpSrc2;
    logic              ack;
    fpTypes::word_t    intResult;
    fpTypes::word_t    fpResult;
    logic              writeFlags;
    fpTypes::fflags_t  flagsValue;

    result_t           actQ[$];           // sampled DUT results
    result_t           expQ[$];           // model results, same order
    fpTypes::word_t    rngState = 32'hd5f0;
    int                errorCount = 0;
    int                checkCount = 0;
    int                testsRun = 0;
    int                testsFailed = 0;
    fpTypes::fpClass_t classSeen = '0;

    fpuTop dut_i (
        .clk        (clk),
        .arstN      (arstN),
        .req        (req),
        .op         (op),
        .intSrc     (intSrc),
        .fpSrc1     (fpSrc1),
        .fpSrc2     (fpSrc2),
        .ack        (ack),
        .intResult  (intResult),
        .fpResult   (fpResult),
        .writeFlags (writeFlags),
        .flagsValue (flagsValue)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic checkVal(input string name, input logic [31:0] act,
                            input logic [31:0] exp);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("** Error: %s actual 0x%08h expected 0x%08h", name, act, exp);
        end
    endtask

    function automatic fpTypes::word_t xorshift32(input fpTypes::word_t x);
        fpTypes::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic fpTypes::word_t specialValue(input int idx);
        case (idx % 12)
            0:       return 32'h00000000;  // +0
            1:       return 32'h80000000;  // -0
            2:       return 32'h7f800000;  // +inf
            3:       return 32'hff800000;  // -inf
            4:       return 32'h7f800001;  // sNaN
            5:       return 32'hffa00000;  // negative sNaN
            6:       return `FPU_CANON_NAN;
            7:       return 32'hffc12345;  // negative qNaN with payload
            8:       return 32'h00000001;  // smallest +subnormal
            9:       return 32'h807fffff;  // largest -subnormal
            10:      return 32'h3f800000;  // 1.0
            default: return 32'hc0490fdb;  // -pi
        endcase
    endfunction

    // a special value one time in four, else raw random bits
    task automatic randomOperand(output fpTypes::word_t v);
        rngState = xorshift32(rngState);
        v = (rngState[1:0] == 2'b00) ? specialValue(rngState[11:4]) : rngState;
    endtask

    function automatic fpTypes::fpClass_t classOf(input fpTypes::word_t x);
        int idx;
        if (x[30:23] == 8'hff && x[22:0] != 0) begin
            idx = x[22] ? 9 : 8;
        end else if (x[30:23] == 8'hff) begin
            idx = x[31] ? 0 : 7;
        end else if (x[30:23] != 0) begin
            idx = x[31] ? 1 : 6;
        end else if (x[22:0] != 0) begin
            idx = x[31] ? 2 : 5;
        end else begin
            idx = x[31] ? 3 : 4;
        end
        return 10'b1 << idx;
    endfunction

    // unsigned key in total order, -0 just below +0
    function automatic logic [31:0] orderKey(input fpTypes::word_t x);
        return x[31] ? ~x : (x | 32'h80000000);
    endfunction

    function automatic result_t fpuModel(input logic [3:0] opCode, input fpTypes::word_t iSrc,
                                         input fpTypes::word_t a, input fpTypes::word_t b);
        result_t           r;
        fpTypes::fpClass_t aCls;
        fpTypes::fpClass_t bCls;
        logic              anyNan;
        logic              sNan;
        logic              zeros;
        logic              lt;
        logic              eq;
        r      = '0;
        aCls   = classOf(a);
        bCls   = classOf(b);
        anyNan = |aCls[9:8] | |bCls[9:8];
        sNan   = aCls[8] | bCls[8];
        zeros  = (a[30:0] == 0) && (b[30:0] == 0);
        lt     = (orderKey(a) < orderKey(b)) && !zeros;
        eq     = (a == b) || zeros;
        case (opCode)
            fpTypes::FpOp_MvXW:  r.intRes = a;
            fpTypes::FpOp_MvWX:  r.fpRes = iSrc;
            fpTypes::FpOp_Class: r.intRes = aCls;
            fpTypes::FpOp_Sgnj:  r.fpRes = {b[31], a[30:0]};
            fpTypes::FpOp_Sgnjn: r.fpRes = {~b[31], a[30:0]};
            fpTypes::FpOp_Sgnjx: r.fpRes = {a[31] ^ b[31], a[30:0]};
            fpTypes::FpOp_Eq: begin
                r.intRes = !anyNan && eq;
                r.flags[`FPU_FLAG_NV] = sNan;
            end
            fpTypes::FpOp_Lt, fpTypes::FpOp_Le: begin
                r.intRes = !anyNan && (lt || (eq && opCode == fpTypes::FpOp_Le));
                r.flags[`FPU_FLAG_NV] = anyNan;
            end
            fpTypes::FpOp_Min, fpTypes::FpOp_Max: begin
                if (|aCls[9:8] && |bCls[9:8]) begin
                    r.fpRes = `FPU_CANON_NAN;
                end else if (|aCls[9:8]) begin
                    r.fpRes = b;
                end else if (|bCls[9:8]) begin
                    r.fpRes = a;
                end else if ((orderKey(a) < orderKey(b)) == (opCode == fpTypes::FpOp_Min)) begin
                    r.fpRes = a;
                end else begin
                    r.fpRes = b;
                end
                r.flags[`FPU_FLAG_NV] = sNan;
            end
            default: r = '0;  // illegal codes
        endcase
        r.wrFlags = (opCode >= fpTypes::FpOp_Eq) && (opCode <= fpTypes::FpOp_Max);
        return r;
    endfunction

    // compares queued samples against the model one edge after they were taken
    always @(posedge clk) begin
        result_t a;
        result_t e;
        while (actQ.size() > 0) begin
            a = actQ.pop_front();
            e = expQ.pop_front();
            checkVal("intResult", a.intRes, e.intRes);
            checkVal("fpResult", a.fpRes, e.fpRes);
            checkVal("writeFlags", a.wrFlags, e.wrFlags);
            checkVal("flagsValue", a.flags, e.flags);
        end
    end

    task automatic runRequest(input logic [3:0] opCode, input fpTypes::word_t iSrc,
                              input fpTypes::word_t a, input fpTypes::word_t b, input int hold);
        int             cycles;
        int             i;
        fpTypes::word_t junk;
        result_t        expected;
        result_t        got;
        expected = fpuModel(opCode, iSrc, a, b);
        @(posedge clk);
        req    <= 1'b1;
        op     <= fpTypes::fpOp_t'(opCode);
        intSrc <= iSrc;
        fpSrc1 <= a;
        fpSrc2 <= b;
        cycles = 0;
        while (ack !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== 1'b1) begin
            errorCount++;
            $display("timeout: no ack within 20 cycles for op %0d", opCode);
        end else begin
            checkVal("ackLatency", cycles, 3);  // drive, capture, result edge
            for (i = 0; i <= hold; i++) begin
                if (i > 0) begin
                    randomOperand(junk);
                    @(posedge clk);
                    fpSrc1 <= junk;  // captured already, must not matter
                    fpSrc2 <= ~junk;
                    @(negedge clk);
                    checkVal("ack", ack, 1'b1);
                end
                got = {intResult, fpResult, writeFlags, flagsValue};
                actQ.push_back(got);
                expQ.push_back(expected);
            end
        end
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        while (ack !== 1'b0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== 1'b0) begin
            errorCount++;
            $display("timeout: ack still high 20 cycles after req dropped");
        end
    endtask

    // all special pairs, then random pairs with some equal and sign-flipped operands
    task automatic sweepOps(input int lo, input int hi);
        int             i;
        int             j;
        int             k;
        fpTypes::word_t a;
        fpTypes::word_t b;
        for (i = 0; i < 12; i++) begin
            for (j = 0; j < 12; j++) begin
                for (k = lo; k <= hi; k++) begin
                    runRequest(k, 0, specialValue(i), specialValue(j), 0);
                end
            end
        end
        for (i = 0; i < 24; i++) begin
            randomOperand(a);
            randomOperand(b);
            if (i % 3 == 0) begin
                b = a;
            end else if (i % 3 == 1) begin
                b = {~a[31], a[30:0]};
            end
            for (k = lo; k <= hi; k++) begin
                runRequest(k, 0, a, b, 0);
            end
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        int cycles;
        cycles = 0;
        while (actQ.size() > 0 && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (actQ.size() > 0) begin
            errorCount++;
            $display("checker queue not drained at end of test %s", name);
        end
        testsRun++;
        if (errorCount != errorsBefore) begin
            testsFailed++;
        end
        $display("test %s: %s, %0d errors", name,
                 (errorCount == errorsBefore) ? "ok" : "FAILED", errorCount - errorsBefore);
    endtask

    initial begin
        int             i;
        int             mark;
        fpTypes::word_t a;
        fpTypes::word_t b;
        fpTypes::word_t c;
        arstN  = 1'b0;
        req    = 1'b0;
        op     = fpTypes::FpOp_MvXW;
        intSrc = '0;
        fpSrc1 = '0;
        fpSrc2 = '0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);

        mark = errorCount;
        checkVal("ack", ack, 1'b0);
        checkVal("writeFlags", writeFlags, 1'b0);
        checkVal("intResult", intResult, 0);
        checkVal("fpResult", fpResult, 0);
        checkVal("flagsValue", flagsValue, 0);
        for (i = 0; i < 12; i++) begin
            randomOperand(a);
            randomOperand(b);
            randomOperand(c);
            runRequest(c[3:0] % 11, c, a, b, i % 4);  // holds of 0 to 3 extra cycles
        end
        finishTest("handshake", mark);

        mark = errorCount;
        for (i = 0; i < 36; i++) begin
            if (i < 12) begin
                a = specialValue(i);
            end else begin
                randomOperand(a);
            end
            randomOperand(b);
            runRequest(fpTypes::FpOp_MvXW, b, a, b, 0);
            runRequest(fpTypes::FpOp_MvWX, a, b, a, 0);
            runRequest(fpTypes::FpOp_Class, b, a, b, 0);
            classSeen = classSeen | intResult[`FPU_CLASS_BITS-1:0];  // held after ack drops
        end
        checkVal("classCoverage", classSeen, 10'h3ff);
        finishTest("moveClass", mark);

        mark = errorCount;
        sweepOps(fpTypes::FpOp_Sgnj, fpTypes::FpOp_Sgnjx);
        finishTest("signInject", mark);

        mark = errorCount;
        sweepOps(fpTypes::FpOp_Eq, fpTypes::FpOp_Le);
        finishTest("compare", mark);

        mark = errorCount;
        sweepOps(fpTypes::FpOp_Min, fpTypes::FpOp_Max);
        finishTest("minMax", mark);

        mark = errorCount;
        for (i = 11; i <= 15; i++) begin
            randomOperand(a);
            randomOperand(b);
            randomOperand(c);
            runRequest(i, c, a, b, 1);
        end
        finishTest("illegalOp", mark);

        $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 testsRun, testsRun - testsFailed, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
